// File: hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;                        // Data and address word
    typedef logic [4:0]  reg_addr_t;                    // Register index

    localparam reg_addr_t REG_RA     = 5'd31;           // Link register of jal
    localparam int        DMEM_WORDS = 64;
    localparam int        DMEM_AW    = $clog2(DMEM_WORDS);

    // Primary opcodes, instruction bits 31:26
    localparam logic [5:0] OPCODE_R     = 6'h00;
    localparam logic [5:0] OPCODE_J     = 6'h02;
    localparam logic [5:0] OPCODE_JAL   = 6'h03;
    localparam logic [5:0] OPCODE_BEQ   = 6'h04;
    localparam logic [5:0] OPCODE_BNE   = 6'h05;
    localparam logic [5:0] OPCODE_ADDIU = 6'h09;
    localparam logic [5:0] OPCODE_LW    = 6'h23;
    localparam logic [5:0] OPCODE_SW    = 6'h2b;

    // Function codes of R-type, bits 5:0
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_SLT  = 6'h2a;
    localparam logic [5:0] FUNCT_JR   = 6'h08;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_ctrl_t;
    typedef enum logic [1:0] {SEL_PC_PLUS4, SEL_PC_BRANCH, SEL_PC_JUMP, SEL_PC_REG} sel_pc_t;
    typedef enum logic [1:0] {SEL_RESULT_DMEM, SEL_RESULT_ALU, SEL_RESULT_LINK} sel_result_t;
    typedef enum logic [1:0] {SEL_WA_RT, SEL_WA_RD, SEL_WA_RA} sel_wa_t;

    typedef struct packed {
        alu_ctrl_t   alu_ctrl;
        logic        rf_we;
        logic        sel_alu_b;                         // Immediate on ALU port B
        sel_pc_t     sel_pc;
        sel_result_t sel_result;
        sel_wa_t     sel_wa;
        logic        dmem_we;
        logic        is_branch;
        logic        branch_ne;                         // Taken on not equal
        logic        reads_rs;                          // Used by hazard check
        logic        reads_rt;
    } ctrl_t;

    typedef struct packed {
        word_t instruction;
        word_t pc_plus4;
    } decode_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rd0;
        word_t     rd1;
        word_t     sign_imm;
        reg_addr_t wa0;                                 // rt field
        reg_addr_t wa1;                                 // rd field
        word_t     pc_plus4;
    } execute_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rf_wa;
        word_t     alu_out;
        logic      zero;
        word_t     dmem_wd;
        word_t     pc_plus4;
        word_t     branch_addr;                         // Target for beq and bne
    } memory_t;

    typedef struct packed {
        sel_result_t sel_result;
        logic        rf_we;
        reg_addr_t   rf_wa;
        word_t       alu_out;
        word_t       dmem_rd;
        word_t       pc_plus4;
    } writeback_t;

endpackage

`default_nettype wire

// File: hdl/pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     hold,                              // Keep current stage
    input  logic     bubble,                            // Load a no-op
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clock) begin
        if (reset || bubble) begin
            q <= '0;                                    // All-zero payload is a no-op
        end else if (!hold) begin
            q <= d;
        end
    end

    // The flusher never asks a stage to keep and clear in the same cycle
    assert property (@(posedge clock) disable iff (reset) !(hold && bubble));

endmodule

`default_nettype wire

// File: hdl/control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  mips_pkg::word_t instruction,
    output mips_pkg::ctrl_t ctrl
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instruction[31:26];
    assign funct  = instruction[5:0];

    always_comb begin
        ctrl = '0;                                      // No-op unless decoded below
        unique case (opcode)
            OPCODE_R: begin
                ctrl.rf_we      = 1'b1;
                ctrl.sel_wa     = SEL_WA_RD;
                ctrl.sel_result = SEL_RESULT_ALU;
                ctrl.reads_rs   = 1'b1;
                ctrl.reads_rt   = 1'b1;
                case (funct)
                    FUNCT_ADDU: ctrl.alu_ctrl = ALU_ADD;
                    FUNCT_SUBU: ctrl.alu_ctrl = ALU_SUB;
                    FUNCT_AND:  ctrl.alu_ctrl = ALU_AND;
                    FUNCT_OR:   ctrl.alu_ctrl = ALU_OR;
                    FUNCT_SLT:  ctrl.alu_ctrl = ALU_SLT;
                    FUNCT_JR: begin
                        ctrl          = '0;             // Only reads rs
                        ctrl.sel_pc   = SEL_PC_REG;
                        ctrl.reads_rs = 1'b1;
                    end
                    default:    ctrl = '0;              // Includes sll $0 bubble
                endcase
            end
            OPCODE_ADDIU, OPCODE_LW: begin
                ctrl.rf_we      = 1'b1;
                ctrl.sel_alu_b  = 1'b1;
                ctrl.sel_wa     = SEL_WA_RT;
                ctrl.sel_result = (opcode == OPCODE_LW) ? SEL_RESULT_DMEM : SEL_RESULT_ALU;
                ctrl.reads_rs   = 1'b1;
            end
            OPCODE_SW: begin
                ctrl.dmem_we   = 1'b1;
                ctrl.sel_alu_b = 1'b1;                  // Base plus offset
                ctrl.reads_rs  = 1'b1;
                ctrl.reads_rt  = 1'b1;                  // Store data
            end
            OPCODE_BEQ, OPCODE_BNE: begin
                ctrl.alu_ctrl  = ALU_SUB;               // Zero flag gives equality
                ctrl.sel_pc    = SEL_PC_BRANCH;
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = (opcode == OPCODE_BNE);
                ctrl.reads_rs  = 1'b1;
                ctrl.reads_rt  = 1'b1;
            end
            OPCODE_J:   ctrl.sel_pc = SEL_PC_JUMP;      // Redirected at fetch
            OPCODE_JAL: begin
                ctrl.sel_pc     = SEL_PC_JUMP;
                ctrl.rf_we      = 1'b1;
                ctrl.sel_wa     = SEL_WA_RA;
                ctrl.sel_result = SEL_RESULT_LINK;
            end
            default:    ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/flusher.sv
`timescale 1ns/1ns
`default_nettype none

module flusher (
    input  logic                clock,
    input  logic                reset,
    input  mips_pkg::word_t     instruction,        // Decode-stage instruction
    input  mips_pkg::ctrl_t     d_ctrl,
    input  mips_pkg::reg_addr_t e_wa,
    input  logic                e_we,
    input  mips_pkg::reg_addr_t m_wa,
    input  logic                m_we,
    output logic                stall,              // Hold PC and decode
    output logic                bubble              // Hold PC and clear decode
);
    import mips_pkg::*;

    reg_addr_t rs;
    reg_addr_t rt;
    logic      d_redirect;
    logic      e_redirect;                          // Branch or jr in execute
    logic      m_redirect;                          // Branch or jr in memory

    // Source still owed by an older instruction
    function automatic logic in_flight(reg_addr_t ra, reg_addr_t e_dst, logic e_wr,
                                       reg_addr_t m_dst, logic m_wr);
        return (ra != '0) && ((e_wr && ra == e_dst) || (m_wr && ra == m_dst));
    endfunction

    assign rs = instruction[25:21];
    assign rt = instruction[20:16];

    assign stall = (d_ctrl.reads_rs && in_flight(rs, e_wa, e_we, m_wa, m_we))
                || (d_ctrl.reads_rt && in_flight(rt, e_wa, e_we, m_wa, m_we));

    assign d_redirect = d_ctrl.is_branch || (d_ctrl.sel_pc == SEL_PC_REG);

    always_ff @(posedge clock) begin
        if (reset) begin
            e_redirect <= 1'b0;
            m_redirect <= 1'b0;
        end else begin
            e_redirect <= d_redirect && !stall;     // Enters execute only when not held
            m_redirect <= e_redirect;
        end
    end

    // Stall wins so a held branch stays in decode
    assign bubble = (d_redirect || e_redirect || m_redirect) && !stall;

    // Writeback drains a producer within two cycles plus one of margin
    assert property (@(posedge clock) disable iff (reset) stall [*3] |=> !stall);

endmodule

`default_nettype wire

// File: hdl/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic                clock,
    input  logic                we,
    input  mips_pkg::reg_addr_t wa,
    input  mips_pkg::word_t     wd,
    input  mips_pkg::reg_addr_t ra0,
    input  mips_pkg::reg_addr_t ra1,
    input  mips_pkg::reg_addr_t ra2,                // Debug port
    output mips_pkg::word_t     rd0,
    output mips_pkg::word_t     rd1,
    output mips_pkg::word_t     rd2
);
    import mips_pkg::*;

    word_t regs [32];

    // Zero register and write-through bypass
    function automatic word_t read_port(reg_addr_t ra);
        if (ra == '0) return '0;
        if (we && ra == wa) return wd;
        return regs[ra];
    endfunction

    always_ff @(posedge clock) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd0 = read_port(ra0);
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

    // Writes to $0 are dropped upstream in execute
    assert property (@(posedge clock) !(we && wa == '0 && wd != '0));

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  mips_pkg::word_t     a,
    input  mips_pkg::word_t     b,
    input  mips_pkg::alu_ctrl_t sel,
    output mips_pkg::word_t     y,
    output logic                zero
);
    import mips_pkg::*;

    logic less;

    assign less = $signed(a) < $signed(b);             // Signed compare for slt

    always_comb begin
        case (sel)
            ALU_ADD: y = a + b;                         // addu, addiu, lw, sw
            ALU_SUB: y = a - b;                         // subu, beq, bne
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_SLT: y = {31'd0, less};
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

`default_nettype wire

// File: hdl/dmem.sv
`timescale 1ns/1ns
`default_nettype none

module dmem (
    input  logic            clock,
    input  logic            reset,
    input  logic            we,
    input  mips_pkg::word_t addr,                   // Byte address
    input  mips_pkg::word_t wd,
    output mips_pkg::word_t rd
);
    import mips_pkg::*;

    word_t              mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] index;

    assign index = addr[DMEM_AW+1:2];               // Word index

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[index] <= wd;
        end
    end

    assign rd = mem[index];                         // Asynchronous read

endmodule

`default_nettype wire

// File: hdl/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath (
    input  logic                clock,
    input  logic                reset,
    input  mips_pkg::word_t     instruction,
    output mips_pkg::word_t     pc,
    output mips_pkg::word_t     d_instruction,      // To control unit and flusher
    input  mips_pkg::ctrl_t     ctrl,
    input  logic                stall,
    input  logic                bubble,
    output mips_pkg::reg_addr_t e_wa,
    output logic                e_we,
    output mips_pkg::reg_addr_t m_wa,
    output logic                m_we,
    output logic                dmem_we,
    output mips_pkg::word_t     dmem_addr,
    output mips_pkg::word_t     dmem_wd,
    input  mips_pkg::word_t     dmem_rd,
    input  mips_pkg::reg_addr_t dbg_ra,
    output mips_pkg::word_t     dbg_rd
);
    import mips_pkg::*;

    decode_t    d_in, d_q;
    execute_t   e_in, e_q;
    memory_t    m_in, m_q;
    writeback_t w_in, w_q;

    word_t pc_plus4, jump_addr, alu_b, alu_out, result;
    logic  fetch_jump, branch_taken, jr_taken, alu_zero;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////////////////////

    assign pc_plus4     = pc + 32'd4;
    assign fetch_jump   = (instruction[31:26] == OPCODE_J) || (instruction[31:26] == OPCODE_JAL);
    assign jump_addr    = {pc_plus4[31:28], instruction[25:0], 2'b00};
    assign branch_taken = m_q.ctrl.is_branch && (m_q.zero != m_q.ctrl.branch_ne);
    assign jr_taken     = (e_q.ctrl.sel_pc == SEL_PC_REG);

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= m_q.branch_addr;                  // Resolved in memory
        end else if (jr_taken) begin
            pc <= e_q.rd0;                          // Target from execute
        end else if (!stall && !bubble) begin
            pc <= fetch_jump ? jump_addr : pc_plus4;
        end
    end

    assign d_in.instruction = instruction;
    assign d_in.pc_plus4    = pc_plus4;

    pipe_reg #(.payload_t(decode_t)) decode_register (
        .clock(clock), .reset(reset), .hold(stall), .bubble(bubble), .d(d_in), .q(d_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    assign d_instruction = d_q.instruction;
    assign e_in.ctrl     = ctrl;
    assign e_in.sign_imm = {{16{d_q.instruction[15]}}, d_q.instruction[15:0]};
    assign e_in.wa0      = d_q.instruction[20:16];
    assign e_in.wa1      = d_q.instruction[15:11];
    assign e_in.pc_plus4 = d_q.pc_plus4;

    regfile rf (
        .clock(clock),
        .we   (w_q.rf_we),                          // From writeback
        .wa   (w_q.rf_wa),
        .wd   (result),
        .ra0  (d_q.instruction[25:21]),
        .ra1  (d_q.instruction[20:16]),
        .ra2  (dbg_ra),
        .rd0  (e_in.rd0),
        .rd1  (e_in.rd1),
        .rd2  (dbg_rd)
    );

    pipe_reg #(.payload_t(execute_t)) execute_register (
        .clock(clock), .reset(reset), .hold(1'b0), .bubble(stall), .d(e_in), .q(e_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////////////////////

    assign alu_b = e_q.ctrl.sel_alu_b ? e_q.sign_imm : e_q.rd1;

    alu alu_unit (.a(e_q.rd0), .b(alu_b), .sel(e_q.ctrl.alu_ctrl), .y(alu_out), .zero(alu_zero));

    always_comb begin
        case (e_q.ctrl.sel_wa)
            SEL_WA_RD: e_wa = e_q.wa1;
            SEL_WA_RA: e_wa = REG_RA;
            default:   e_wa = e_q.wa0;
        endcase
    end

    assign e_we = e_q.ctrl.rf_we && (e_wa != '0);   // Writes to $0 dropped here

    always_comb begin
        m_in             = '0;
        m_in.ctrl        = e_q.ctrl;
        m_in.ctrl.rf_we  = e_we;
        m_in.rf_wa       = e_wa;
        m_in.alu_out     = alu_out;
        m_in.zero        = alu_zero;
        m_in.dmem_wd     = e_q.rd1;                 // Store data from rt
        m_in.pc_plus4    = e_q.pc_plus4;
        m_in.branch_addr = e_q.pc_plus4 + {e_q.sign_imm[29:0], 2'b00};
    end

    pipe_reg #(.payload_t(memory_t)) memory_register (
        .clock(clock), .reset(reset), .hold(1'b0), .bubble(1'b0), .d(m_in), .q(m_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory and writeback
    ////////////////////////////////////////////////////////////////////////////

    assign m_wa      = m_q.rf_wa;
    assign m_we      = m_q.ctrl.rf_we;
    assign dmem_we   = m_q.ctrl.dmem_we;
    assign dmem_addr = m_q.alu_out;
    assign dmem_wd   = m_q.dmem_wd;

    assign w_in.sel_result = m_q.ctrl.sel_result;
    assign w_in.rf_we      = m_q.ctrl.rf_we;
    assign w_in.rf_wa      = m_q.rf_wa;
    assign w_in.alu_out    = m_q.alu_out;
    assign w_in.dmem_rd    = dmem_rd;
    assign w_in.pc_plus4   = m_q.pc_plus4;

    pipe_reg #(.payload_t(writeback_t)) writeback_register (
        .clock(clock), .reset(reset), .hold(1'b0), .bubble(1'b0), .d(w_in), .q(w_q)
    );

    always_comb begin
        case (w_q.sel_result)
            SEL_RESULT_DMEM: result = w_q.dmem_rd;
            SEL_RESULT_LINK: result = w_q.pc_plus4 + 32'd4;     // jal links pc+8
            default:         result = w_q.alu_out;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core (
    input  logic                clock,
    input  logic                reset,
    input  mips_pkg::word_t     instruction,        // From external instruction memory
    output mips_pkg::word_t     pc,
    input  mips_pkg::reg_addr_t dbg_ra,
    output mips_pkg::word_t     dbg_rd,
    output logic                store_we,
    output mips_pkg::word_t     store_addr,
    output mips_pkg::word_t     store_data
);
    import mips_pkg::*;

    word_t     d_instruction, dmem_rd;
    ctrl_t     ctrl;
    reg_addr_t e_wa, m_wa;
    logic      e_we, m_we, stall, bubble;

    datapath dp (
        .clock(clock), .reset(reset), .instruction(instruction), .pc(pc),
        .d_instruction(d_instruction), .ctrl(ctrl), .stall(stall), .bubble(bubble),
        .e_wa(e_wa), .e_we(e_we), .m_wa(m_wa), .m_we(m_we),
        .dmem_we(store_we), .dmem_addr(store_addr), .dmem_wd(store_data),
        .dmem_rd(dmem_rd), .dbg_ra(dbg_ra), .dbg_rd(dbg_rd)
    );

    control_unit cu (.instruction(d_instruction), .ctrl(ctrl));

    flusher hazard (
        .clock(clock), .reset(reset), .instruction(d_instruction), .d_ctrl(ctrl),
        .e_wa(e_wa), .e_we(e_we), .m_wa(m_wa), .m_we(m_we), .stall(stall), .bubble(bubble)
    );

    dmem data_mem (
        .clock(clock), .reset(reset), .we(store_we), .addr(store_addr),
        .wd(store_data), .rd(dmem_rd)
    );

endmodule

`default_nettype wire

// File: tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// One write seen on the store port
typedef struct packed {
    mips_pkg::word_t addr;                              // Byte address
    mips_pkg::word_t data;
} store_t;

localparam logic [31:0] LCG_SEED = 32'h68040bc3;

int reg_errors   = 0;                                   // Wrong register values
int store_errors = 0;                                   // Wrong store address or data
int other_errors = 0;                                   // Timeouts, file and sequence faults
int check_count  = 0;

// Full-period 32-bit LCG
function automatic logic [31:0] next_random(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Register or other single-word result
task automatic check_word(string what, mips_pkg::word_t got, mips_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
        reg_errors++;
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

// Address and data of the n-th store in program order
task automatic check_store(int index, store_t got, store_t exp);
    check_count++;
    if (got !== exp) begin
        store_errors++;
        $display("CHECK FAILED at %0t ns: store %0d wrote %h to %h, expected %h to %h",
                 $time, index, got.data, got.addr, exp.data, exp.addr);
    end
endtask

`endif

// File: tb/tb_mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_core;
    import mips_pkg::*;

    `include "tb_checks.svh"

    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DRAIN      = 8;                      // Cycles for the last instruction to retire

    logic      clock;
    logic      reset;
    word_t     instruction;
    word_t     pc;
    reg_addr_t dbg_ra;
    word_t     dbg_rd;
    logic      store_we;
    word_t     store_addr;
    word_t     store_data;

    word_t  imem [IMEM_WORDS];                          // Instruction memory model
    word_t  expected_regs [32];
    logic   has_expected [32];
    store_t expected_stores [$];
    int     prog_len    = 0;
    int     store_index = 0;
    int     cycle_count = 0;
    int     cycle_limit = 0;
    word_t  halt_addr   = '0;
    logic   halt_found  = 1'b0;

    mips_core uut (
        .clock(clock), .reset(reset), .instruction(instruction), .pc(pc),
        .dbg_ra(dbg_ra), .dbg_rd(dbg_rd), .store_we(store_we),
        .store_addr(store_addr), .store_data(store_data)
    );

    assign instruction = imem[pc[IMEM_AW+1:2]];         // Combinational fetch

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;                     // 20 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // Golden file and run sequence
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_golden();
        int        fd;
        int        code;
        int        ch;
        byte       kind;
        word_t     value;
        word_t     addr;
        reg_addr_t index;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {OPCODE_J, 26'(i)};               // Unused words jump to themselves
        end
        for (int i = 0; i < 32; i++) begin
            has_expected[i] = 1'b0;
        end
        fd = $fopen("tb/mips_core_golden.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the golden file tb/mips_core_golden.txt");
            return;
        end
        forever begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) break;                       // End of file
            case (kind)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) ch = $fgetc(fd);
                end
                "I": begin
                    code = $fscanf(fd, "%h", value);
                    if (code != 1) begin
                        other_errors++;
                        $display("Malformed program word record in the golden file");
                    end else begin
                        imem[prog_len] = value;
                        prog_len++;
                    end
                end
                "S": begin
                    code = $fscanf(fd, "%h %h", addr, value);
                    if (code != 2) begin
                        other_errors++;
                        $display("Malformed store record in the golden file");
                    end else begin
                        expected_stores.push_back('{addr: addr, data: value});
                    end
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", index, value);
                    if (code != 2) begin
                        other_errors++;
                        $display("Malformed register record in the golden file");
                    end else begin
                        expected_regs[index] = value;
                        has_expected[index]  = 1'b1;
                    end
                end
                default: begin
                    other_errors++;
                    $display("Unknown record kind '%c' in the golden file", kind);
                end
            endcase
        end
        $fclose(fd);
        for (int i = 0; i < prog_len; i++) begin
            if (!halt_found && imem[i] == {OPCODE_J, 26'(i)}) begin
                halt_addr  = word_t'(i * 4);            // First jump to self
                halt_found = 1'b1;
            end
        end
        if (!halt_found) begin
            other_errors++;
            $display("The golden program has no jump-to-self halt word");
        end
        cycle_limit = 40 * prog_len;
    endtask

    task automatic run_program();
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        while (pc !== halt_addr) @(negedge clock);
        repeat (DRAIN) @(posedge clock);
    endtask

    // Debug port read of every register in shuffled order
    task automatic sweep_registers();
        int          order [32];
        int          pick;
        int          swap;
        logic [31:0] state;
        state = LCG_SEED;
        for (int i = 0; i < 32; i++) begin
            order[i] = i;
        end
        for (int i = 31; i > 0; i--) begin
            state       = next_random(state);
            pick        = int'(state[31:16]) % (i + 1);     // Index from the upper half
            swap        = order[i];
            order[i]    = order[pick];
            order[pick] = swap;
        end
        foreach (order[i]) begin
            @(posedge clock);
            dbg_ra <= reg_addr_t'(order[i]);
            @(negedge clock);
            if (has_expected[order[i]]) begin
                check_word($sformatf("register %0d", order[i]), dbg_rd, expected_regs[order[i]]);
            end
        end
    endtask

    task automatic report_and_finish();
        int total;
        total = reg_errors + store_errors + other_errors;
        $display("Errors: %0d register, %0d store, %0d other, in %0d checks",
                 reg_errors, store_errors, other_errors, check_count);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin : sequencer
        reset  = 1'b1;
        dbg_ra = '0;
        load_golden();
        if (halt_found) begin
            run_program();
            sweep_registers();
            if (expected_stores.size() != 0) begin
                other_errors++;
                $display("%0d expected stores never appeared", expected_stores.size());
            end
        end
        report_and_finish();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Store watcher and timeout
    ////////////////////////////////////////////////////////////////////////////

    initial begin : store_watch
        store_t seen;
        forever begin
            @(negedge clock);
            if (!reset && store_we) begin               // One cycle per sw in memory stage
                seen.addr = store_addr;
                seen.data = store_data;
                if (expected_stores.size() == 0) begin
                    other_errors++;
                    $display("Unexpected store of %h to %h at %0t ns", seen.data, seen.addr, $time);
                end else begin
                    check_store(store_index, seen, expected_stores.pop_front());
                end
                store_index++;
            end
        end
    end

    initial begin : watchdog
        @(posedge clock);                               // Limit known once the file is read
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        other_errors++;
        $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
        report_and_finish();
    end

endmodule

`default_nettype wire

// File: tb/mips_core_golden.txt
# Records are whitespace separated, any number per line, all numbers hex
#   I <word>          program word, placed at consecutive addresses from 0
#   S <addr> <data>   expected store, in program order
#   R <reg> <value>   expected final register value
I 24010005  I 2402000C   # 00 addiu $1,5           04 addiu $2,12
I 00221821  I 00412023   # 08 addu $3,$1,$2        0C subu $4,$2,$1
I 00642824  I 00623025   # 10 and $5,$3,$4         14 or $6,$3,$2
I 2407FFFD  I 00E1402A   # 18 addiu $7,-3          1C slt $8,$7,$1
I 0027482A  I 24000063   # 20 slt $9,$1,$7         24 addiu $0,99
I 00220021  I 240A0040   # 28 addu $0,$1,$2        2C addiu $10,0x40
I AD430000  I AD460004   # 30 sw $3,0($10)         34 sw $6,4($10)
I AD47FFF8  I 8D4B0004   # 38 sw $7,-8($10)        3C lw $11,4($10)
I 8D4CFFF8  I 016C6821   # 40 lw $12,-8($10)       44 addu $13,$11,$12
I AD4D0008  I 240E000A   # 48 sw $13,8($10)        4C addiu $14,0xA marker
I 10210001  I 240E0BAD   # 50 beq $1,$1 taken      54 skipped
I 14220001  I 240E0BAD   # 58 bne $1,$2 taken      5C skipped
I 10220001  I 240F0111   # 60 beq $1,$2 not taken  64 addiu $15,0x111
I 14210001  I 24100222   # 68 bne $1,$1 not taken  6C addiu $16,0x222
I 24110003  I 24120000   # 70 addiu $17,3          74 addiu $18,0
I 02519021  I 2631FFFF   # 78 addu $18,$18,$17     7C addiu $17,$17,-1
I 1620FFFD  I 0C000028   # 80 bne $17,$0 to 78     84 jal A0
I 240E0BAD  I 027FA021   # 88 never fetched        8C addu $20,$19,$31
I AD54000C  I 08000027   # 90 sw $20,12($10)       94 j 9C
I 240E0BAD  I 08000027   # 98 skipped              9C halt
I 24130055  I 03E00008   # A0 addiu $19,0x55       A4 jr $31
I 240E0BAD               # A8 never run
S 00000040 00000011  S 00000044 0000001D  S 00000038 FFFFFFFD
S 00000048 0000001A  S 0000004C 000000E1
R 00 00000000  R 01 00000005  R 02 0000000C  R 03 00000011  R 04 00000007
R 05 00000001  R 06 0000001D  R 07 FFFFFFFD  R 08 00000001  R 09 00000000
R 0A 00000040  R 0B 0000001D  R 0C FFFFFFFD  R 0D 0000001A  R 0E 0000000A
R 0F 00000111  R 10 00000222  R 11 00000000  R 12 00000006  R 13 00000055
R 14 000000E1  R 1F 0000008C

// File: mips_core.f
+incdir+tb
hdl/mips_pkg.sv
hdl/pipe_reg.sv
hdl/control_unit.sv
hdl/flusher.sv
hdl/regfile.sv
hdl/alu.sv
hdl/dmem.sv
hdl/datapath.sv
hdl/mips_core.sv
tb/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mips_core -f mips_core.f --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\* PASS \*\*' "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
